// ==== verilog/platform_pkg.sv ====
/*
 * Platform definitions for the card's DDR layout
 * Four DDR channels in shell order A, B, C, D. Channels A, B and D are run
 * by the on-card DDR controller, channel C is owned by the shell.
 * Also holds the ready vector type shared by the glue logic and testbench
 */

`default_nettype none

package platform_pkg;

   // ==========================================================================
   // Channel layout
   // ==========================================================================

   localparam int NUM_DDR_CH = 4;         // Total DDR channels on the card

   // Channel order as the shell numbers them
   // Encoded value doubles as bit index in ddr_ready_t
   typedef enum logic [1:0] {
      DDR_A = 2'd0,                       // Controller managed
      DDR_B = 2'd1,                       // Controller managed
      DDR_C = 2'd2,                       // Shell managed
      DDR_D = 2'd3                        // Controller managed
   } ddr_chan_e;

   // ==========================================================================
   // Ready vector
   // ==========================================================================

   // One bit per channel
   // Index with ddr_chan_e values, never raw numbers
   typedef logic [NUM_DDR_CH-1:0] ddr_ready_t;

endpackage : platform_pkg

`default_nettype wire

// ==== verilog/stat_bus_pkg.sv ====
/*
 * DDR statistics bus definitions
 * Request and response bundles between shell and DDR controller.
 * One op field instead of separate rd/wr strobes so a read and a write
 * can never be requested in the same cycle
 */

`default_nettype none

package stat_bus_pkg;

   // ==========================================================================
   // Widths
   // ==========================================================================

   localparam int STAT_ADDR_W = 8;        // Register address
   localparam int STAT_DATA_W = 32;       // Read and write data
   localparam int STAT_INT_W  = 8;        // Interrupt flags

   // Request opcode
   // All-zero must stay IDLE, pipelines clear to zero
   typedef enum logic [1:0] {
      STAT_IDLE = 2'd0,                   // No request this cycle
      STAT_RD   = 2'd1,                   // Register read
      STAT_WR   = 2'd2                    // Register write
   } stat_op_e;

   // ==========================================================================
   // Bundles
   // ==========================================================================

   // Shell to controller, one cycle per request
   typedef struct packed {
      stat_op_e               op;
      logic [STAT_ADDR_W-1:0] addr;
      logic [STAT_DATA_W-1:0] wdata;      // Don't care on reads
   } stat_req_t;

   // Controller to shell, ack is a single cycle pulse
   typedef struct packed {
      logic                   ack;
      logic [STAT_INT_W-1:0]  intr;
      logic [STAT_DATA_W-1:0] rdata;      // Valid with ack on reads
   } stat_rsp_t;

endpackage : stat_bus_pkg

`default_nettype wire

// ==== verilog/pipe_stage.sv ====
/*
 * Generic register pipeline
 * STAGES flops deep, WIDTH bits wide, asynchronous active low clear.
 * Output is the input delayed by exactly STAGES clock edges.
 * Clear value is all zeros
 */

`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
   parameter int unsigned WIDTH  = 1,     // Bus width
   parameter int unsigned STAGES = 1      // Number of flops, at least 1
)
(
   input  logic             clk_main_a0,
   input  logic             sync_rst_n,   // Async clear, active low
   input  logic [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   // Stage 0 takes the input, last stage feeds out_bus
   logic [WIDTH-1:0] stage_q [STAGES];

   // ==========================================================================
   // Shift chain
   // ==========================================================================

   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
         begin
            stage_q[i] <= '0;             // Whole chain cleared
         end
      end
      else
      begin
         stage_q[0] <= in_bus;            // Sample
         for (int i = 1; i < STAGES; i++)
         begin
            stage_q[i] <= stage_q[i-1];   // Advance one stage
         end
      end
   end

   assign out_bus = stage_q[STAGES-1];

endmodule : pipe_stage

`default_nettype wire

// ==== verilog/reset_fanout.sv ====
/*
 * Reset fan-out
 * Gives the DDR controller and the application their own delayed copy of
 * the main reset. Each copy asserts together with sync_rst_n and releases
 * RST_STAGES clock edges after it, from its own register chain
 */

`timescale 1ns/1ps
`default_nettype none

module reset_fanout #(
   parameter int unsigned RST_STAGES = 4  // Release delay in clock edges
)
(
   input  logic clk_main_a0,
   input  logic sync_rst_n,               // Already synchronized, active low
   output logic ddr_rst_n,                // To DDR controller
   output logic app_rst_n                 // To application
);

   localparam int unsigned NUM_CONS = 2;  // Reset consumers
   localparam int unsigned CONS_DDR = 0;
   localparam int unsigned CONS_APP = 1;

   // One chain per consumer, kept separate so each gets its own tree
   logic [NUM_CONS-1:0][RST_STAGES-1:0] chain_q;

   // ==========================================================================
   // Release chains
   // ==========================================================================

   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         chain_q <= '0;                   // Assert immediately
      end
      else
      begin
         for (int c = 0; c < NUM_CONS; c++)
         begin
            chain_q[c][0] <= 1'b1;        // Fill with ones after release
            for (int s = 1; s < RST_STAGES; s++)
            begin
               chain_q[c][s] <= chain_q[c][s-1];
            end
         end
      end
   end

   assign ddr_rst_n = chain_q[CONS_DDR][RST_STAGES-1];
   assign app_rst_n = chain_q[CONS_APP][RST_STAGES-1];

   // Neither consumer may leave reset while the main reset is held
   a_no_early_release : assert property (
      @(posedge clk_main_a0) !sync_rst_n |-> (!ddr_rst_n && !app_rst_n)
   );

endmodule : reset_fanout

`default_nettype wire

// ==== verilog/shell_ctrl.sv ====
/*
 * Shell control
 * Function-level-reset acknowledge back to the shell, and collection of the
 * DDR ready flags. Channels A, B and D come from the controller as is,
 * channel C comes from the shell and is registered once.
 * The application's environment-ready needs channels A and B
 */

`timescale 1ns/1ps
`default_nettype none

module shell_ctrl
   import platform_pkg::*;
(
   input  logic       clk_main_a0,
   input  logic       sync_rst_n,
   input  logic       flr_assert,         // FLR request from shell
   input  logic       ddr_c_ready,        // Channel C ready, shell side
   input  logic [2:0] ddr_ready_ctl,      // Bits 0..2 are channels A, B, D
   output logic       flr_done,           // FLR acknowledge to shell
   output logic       env_ready,          // To application
   output ddr_ready_t ddr_ready_all       // All four channels
);

   // Index of each channel in ddr_ready_ctl
   localparam int unsigned CTL_A = 0;
   localparam int unsigned CTL_B = 1;
   localparam int unsigned CTL_D = 2;

   logic flr_assert_q;                    // Delayed copy of flr_assert
   logic ddr_c_ready_q;                   // Registered channel C ready

   // ==========================================================================
   // FLR acknowledge
   // ==========================================================================

   // Done pulses one edge after the delayed copy is seen high
   // and toggles for as long as the request stays up
   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

   // ==========================================================================
   // DDR ready collection
   // ==========================================================================

   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ddr_c_ready_q <= 1'b0;
      end
      else
      begin
         ddr_c_ready_q <= ddr_c_ready;    // One cycle on the shell path
      end
   end

   // Place each flag at its shell channel position
   always_comb
   begin
      ddr_ready_all        = '0;
      ddr_ready_all[DDR_A] = ddr_ready_ctl[CTL_A];
      ddr_ready_all[DDR_B] = ddr_ready_ctl[CTL_B];
      ddr_ready_all[DDR_C] = ddr_c_ready_q;
      ddr_ready_all[DDR_D] = ddr_ready_ctl[CTL_D];
   end

   // Application only uses A and B
   assign env_ready = ddr_ready_all[DDR_A] & ddr_ready_all[DDR_B];

   // A rising ack must trace back to a request two edges earlier
   a_flr_done_cause : assert property (
      @(posedge clk_main_a0) disable iff (!sync_rst_n)
      $rose(flr_done) |-> $past(flr_assert, 2)
   );

endmodule : shell_ctrl

`default_nettype wire

// ==== verilog/stat_bridge.sv ====
/*
 * DDR statistics bridge
 * Carries the statistics bus between shell and DDR controller through a
 * fixed depth register pipeline, one per channel and direction.
 * No transaction state, every cycle moves, latency is STAT_STAGES each way
 */

`timescale 1ns/1ps
`default_nettype none

module stat_bridge
   import stat_bus_pkg::*;
#(
   parameter int unsigned NUM_STAT_CH = 3,   // Controller channels A, B, D
   parameter int unsigned STAT_STAGES = 8    // Pipeline depth per direction
)
(
   input  logic      clk_main_a0,
   input  logic      sync_rst_n,
   input  stat_req_t stat_req_in  [NUM_STAT_CH],   // From shell
   input  stat_rsp_t stat_rsp_in  [NUM_STAT_CH],   // From controller
   output stat_req_t stat_req_out [NUM_STAT_CH],   // To controller
   output stat_rsp_t stat_rsp_out [NUM_STAT_CH]    // To shell
);

   localparam int unsigned REQ_W  = $bits(stat_req_t);
   localparam int unsigned RSP_W  = $bits(stat_rsp_t);
   localparam int unsigned PEND_W = 8;       // Outstanding request tracker

   // ==========================================================================
   // Per channel pipelines
   // ==========================================================================

   for (genvar ch = 0; ch < NUM_STAT_CH; ch++)
   begin : g_chan
      logic [PEND_W-1:0] pend_q;             // Requests issued, not yet acked
      logic              req_sent;           // Request leaving toward controller

      // Shell to controller
      pipe_stage #(
         .WIDTH  (REQ_W),
         .STAGES (STAT_STAGES)
      ) i_req_pipe (
         .clk_main_a0 (clk_main_a0),
         .sync_rst_n  (sync_rst_n),
         .in_bus      (stat_req_in[ch]),
         .out_bus     (stat_req_out[ch])
      );

      // Controller to shell
      pipe_stage #(
         .WIDTH  (RSP_W),
         .STAGES (STAT_STAGES)
      ) i_rsp_pipe (
         .clk_main_a0 (clk_main_a0),
         .sync_rst_n  (sync_rst_n),
         .in_bus      (stat_rsp_in[ch]),
         .out_bus     (stat_rsp_out[ch])
      );

      assign req_sent = (stat_req_out[ch].op != STAT_IDLE);

      // Saturating up/down count of requests awaiting ack
      always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
      begin
         if (!sync_rst_n)
         begin
            pend_q <= '0;
         end
         else if (req_sent && !stat_rsp_in[ch].ack && (pend_q != '1))
         begin
            pend_q <= pend_q + 1'b1;
         end
         else if (!req_sent && stat_rsp_in[ch].ack && (pend_q != '0))
         begin
            pend_q <= pend_q - 1'b1;
         end
      end

      // Controller must not ack without a request already sent on this channel
      a_ack_after_req : assert property (
         @(posedge clk_main_a0) disable iff (!sync_rst_n)
         stat_rsp_in[ch].ack |-> (pend_q != '0)
      );
   end

endmodule : stat_bridge

`default_nettype wire

// ==== verilog/cl_glue_top.sv ====
/*
 * Shell-side glue top level
 * Sits between the platform shell and the user design. Fans the main reset
 * out to the DDR controller and the application, answers FLR, bridges the
 * DDR statistics bus for channels A, B, D and collects DDR ready flags
 */

`timescale 1ns/1ps
`default_nettype none

module cl_glue_top
   import platform_pkg::*, stat_bus_pkg::*;
#(
   parameter int unsigned NUM_STAT_CH = 3,   // Controller channels A, B, D
   parameter int unsigned STAT_STAGES = 8,   // Stats pipeline depth
   parameter int unsigned RST_STAGES  = 4    // Reset release delay
)
(
   input  logic                   clk_main_a0,
   input  logic                   sync_rst_n,      // Async, active low
   input  logic                   flr_assert,      // From shell
   input  logic                   ddr_c_ready,     // From shell, channel C
   input  logic [NUM_STAT_CH-1:0] ddr_ready_ctl,   // From controller, A B D

   // Statistics bus, shell side and controller side
   input  stat_req_t              stat_req_shell [NUM_STAT_CH],
   input  stat_rsp_t              stat_rsp_ddr   [NUM_STAT_CH],
   output stat_req_t              stat_req_ddr   [NUM_STAT_CH],
   output stat_rsp_t              stat_rsp_shell [NUM_STAT_CH],

   output logic                   ddr_rst_n,       // To DDR controller
   output logic                   app_rst_n,       // To application
   output logic                   flr_done,        // To shell
   output logic                   env_ready,       // To application
   output ddr_ready_t             ddr_ready_all    // All four channels
);

   // ==========================================================================
   // Reset fan-out
   // ==========================================================================

   reset_fanout #(
      .RST_STAGES (RST_STAGES)
   ) i_reset_fanout (
      .clk_main_a0 (clk_main_a0),
      .sync_rst_n  (sync_rst_n),
      .ddr_rst_n   (ddr_rst_n),
      .app_rst_n   (app_rst_n)
   );

   // ==========================================================================
   // FLR and DDR ready
   // ==========================================================================

   shell_ctrl i_shell_ctrl (
      .clk_main_a0   (clk_main_a0),
      .sync_rst_n    (sync_rst_n),
      .flr_assert    (flr_assert),
      .ddr_c_ready   (ddr_c_ready),
      .ddr_ready_ctl (ddr_ready_ctl),  // Three controller channels
      .flr_done      (flr_done),
      .env_ready     (env_ready),
      .ddr_ready_all (ddr_ready_all)
   );

   // ==========================================================================
   // Statistics bridge
   // ==========================================================================

   // Runs on the main reset, not the delayed DDR copy
   stat_bridge #(
      .NUM_STAT_CH (NUM_STAT_CH),
      .STAT_STAGES (STAT_STAGES)
   ) i_stat_bridge (
      .clk_main_a0  (clk_main_a0),
      .sync_rst_n   (sync_rst_n),
      .stat_req_in  (stat_req_shell),  // Shell requests in
      .stat_rsp_in  (stat_rsp_ddr),    // Controller responses in
      .stat_req_out (stat_req_ddr),    // Toward controller
      .stat_rsp_out (stat_rsp_shell)   // Back to shell
   );

endmodule : cl_glue_top

`default_nettype wire

// ==== verif/tb_cl_glue.sv ====
/*
 * Testbench for the shell-side glue top level
 * Drives stats traffic, FLR pulses and DDR ready flags on the falling edge.
 * Each rising edge compares every DUT output against reference models:
 * per-channel delay queues, the FLR toggle rule, the ready mapping
 */

`timescale 1ns/1ps
`default_nettype none

module tb_cl_glue
   import platform_pkg::*, stat_bus_pkg::*;
();

   localparam int unsigned NUM_STAT_CH = 3;
   localparam int unsigned STAT_STAGES = 8;
   localparam int unsigned RST_STAGES  = 4;
   localparam int unsigned WAIT_LIMIT  = 64;     // Cycles before a wait gives up

   logic                   clk_main_a0;
   logic                   sync_rst_n;
   logic                   flr_assert;
   logic                   ddr_c_ready;
   logic [NUM_STAT_CH-1:0] ddr_ready_ctl;
   stat_req_t              stat_req_shell [NUM_STAT_CH];
   stat_rsp_t              stat_rsp_ddr   [NUM_STAT_CH];
   stat_req_t              stat_req_ddr   [NUM_STAT_CH];
   stat_rsp_t              stat_rsp_shell [NUM_STAT_CH];
   logic                   ddr_rst_n;
   logic                   app_rst_n;
   logic                   flr_done;
   logic                   env_ready;
   ddr_ready_t             ddr_ready_all;

   integer seed = 67;                            // Fixed stimulus seed

   // Reference state, front of each queue is what the DUT shows now
   stat_req_t req_model [NUM_STAT_CH][$];
   stat_rsp_t rsp_model [NUM_STAT_CH][$];
   int        pend_model [NUM_STAT_CH];         // Requests at controller, no ack yet
   logic      flr_q_model;
   logic      flr_done_model;
   logic      c_ready_model;
   int        rst_edges;                         // Edges since reset release

   cl_glue_top #(
      .NUM_STAT_CH (NUM_STAT_CH),
      .STAT_STAGES (STAT_STAGES),
      .RST_STAGES  (RST_STAGES)
   ) i_dut (
      .clk_main_a0    (clk_main_a0),
      .sync_rst_n     (sync_rst_n),
      .flr_assert     (flr_assert),
      .ddr_c_ready    (ddr_c_ready),
      .ddr_ready_ctl  (ddr_ready_ctl),
      .stat_req_shell (stat_req_shell),
      .stat_rsp_ddr   (stat_rsp_ddr),
      .stat_req_ddr   (stat_req_ddr),
      .stat_rsp_shell (stat_rsp_shell),
      .ddr_rst_n      (ddr_rst_n),
      .app_rst_n      (app_rst_n),
      .flr_done       (flr_done),
      .env_ready      (env_ready),
      .ddr_ready_all  (ddr_ready_all)
   );

   initial
   begin
      clk_main_a0 = 1'b0;
      forever #5 clk_main_a0 = ~clk_main_a0;     // 10 ns period
   end

   // ==========================================================================
   // Reference functions
   // ==========================================================================

   // Controller bits A B D in order, C from the registered shell flag
   function automatic ddr_ready_t ref_ready(input logic [2:0] ctl, input logic c_q);
      ddr_ready_t r;
      r        = '0;
      r[DDR_A] = ctl[0];
      r[DDR_B] = ctl[1];
      r[DDR_C] = c_q;
      r[DDR_D] = ctl[2];
      return r;
   endfunction

   function automatic logic ref_env(input ddr_ready_t r);
      return r[DDR_A] & r[DDR_B];                // App needs A and B
   endfunction

   // Next acknowledge from delayed request copy and current acknowledge
   function automatic logic ref_flr_next(input logic flr_q, input logic done);
      return flr_q & ~done;
   endfunction

   // ==========================================================================
   // Error reporting and checks
   // ==========================================================================

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      assert (act === exp)
      else abort_run($sformatf("Fail %s: expected %0h, actual %0h", name, exp, act));
   endtask

   task automatic reset_model();
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         req_model[ch].delete();
         rsp_model[ch].delete();
         repeat (STAT_STAGES)
         begin
            req_model[ch].push_back('0);         // Cleared stage holds IDLE
            rsp_model[ch].push_back('0);
         end
         pend_model[ch] = 0;
      end
      flr_q_model    = 1'b0;
      flr_done_model = 1'b0;
      c_ready_model  = 1'b0;
      rst_edges      = 0;
   endtask

   // Values before the edge, all stable since the last falling edge
   task automatic compare_outputs();
      ddr_ready_t exp_ready;
      exp_ready = ref_ready(ddr_ready_ctl, c_ready_model);
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         check_value($sformatf("stat_req_ddr[%0d]", ch), req_model[ch][0], stat_req_ddr[ch]);
         check_value($sformatf("stat_rsp_shell[%0d]", ch), rsp_model[ch][0],
                     stat_rsp_shell[ch]);
      end
      check_value("ddr_ready_all", exp_ready, ddr_ready_all);
      check_value("env_ready", ref_env(exp_ready), env_ready);
      check_value("flr_done", flr_done_model, flr_done);
      check_value("ddr_rst_n", rst_edges >= RST_STAGES, ddr_rst_n);
      check_value("app_rst_n", rst_edges >= RST_STAGES, app_rst_n);
   endtask

   task automatic advance_model();
      logic sent;
      if (!sync_rst_n)
      begin
         reset_model();
      end
      else
      begin
         for (int ch = 0; ch < NUM_STAT_CH; ch++)
         begin
            sent = (req_model[ch][0].op != STAT_IDLE);    // Leaving toward controller
            if (sent && !stat_rsp_ddr[ch].ack)
               pend_model[ch]++;
            else if (!sent && stat_rsp_ddr[ch].ack)
               pend_model[ch]--;
            void'(req_model[ch].pop_front());
            void'(rsp_model[ch].pop_front());
            req_model[ch].push_back(stat_req_shell[ch]);
            rsp_model[ch].push_back(stat_rsp_ddr[ch]);
         end
         flr_done_model = ref_flr_next(flr_q_model, flr_done_model);
         flr_q_model    = flr_assert;
         c_ready_model  = ddr_c_ready;
         if (rst_edges < RST_STAGES)
            rst_edges++;
      end
   endtask

   // Comparing process
   always @(posedge clk_main_a0)
   begin
      compare_outputs();
      advance_model();
   end

   // ==========================================================================
   // Stimulus
   // ==========================================================================

   task automatic drive_stat(input bit force_busy);
      int pick;
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         pick = $random(seed) & 3;
         if (force_busy && pick == 0)
            pick = 1;                            // Back-to-back burst
         stat_req_shell[ch].op    = (pick == 0) ? STAT_IDLE : (pick == 1) ? STAT_RD : STAT_WR;
         stat_req_shell[ch].addr  = $random(seed);
         stat_req_shell[ch].wdata = $random(seed);
      end
   endtask

   // Ack only for requests already at the controller
   task automatic drive_rsp();
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         stat_rsp_ddr[ch].ack   = (pend_model[ch] > 0) && (($random(seed) & 3) != 0);
         stat_rsp_ddr[ch].intr  = $random(seed);
         stat_rsp_ddr[ch].rdata = $random(seed);
      end
   endtask

   task automatic drive_quiet();
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         stat_req_shell[ch] = '0;
         stat_rsp_ddr[ch]   = '0;
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (!(ddr_rst_n && app_rst_n) && cycles < WAIT_LIMIT)
      begin
         @(negedge clk_main_a0);
         cycles++;
      end
      if (cycles >= WAIT_LIMIT)
         abort_run("Timeout: ddr_rst_n and app_rst_n never left reset");
      else
         check_value("reset release delay", RST_STAGES, cycles);
   endtask

   task automatic wait_flr_done();
      int cycles;
      cycles = 0;
      while (!flr_done && cycles < WAIT_LIMIT)
      begin
         @(negedge clk_main_a0);
         cycles++;
      end
      if (cycles >= WAIT_LIMIT)
         abort_run("Timeout: flr_done never rose after flr_assert");
   endtask

   initial
   begin
      reset_model();
      sync_rst_n    = 1'b1;
      flr_assert    = 1'b0;
      ddr_c_ready   = 1'b0;
      ddr_ready_ctl = '0;
      drive_quiet();
      #1 sync_rst_n = 1'b0;                      // Clear lands before the first edge

      repeat (8) @(posedge clk_main_a0);         // Reset held 8 cycles
      @(negedge clk_main_a0);
      sync_rst_n = 1'b1;
      wait_reset_release();

      // Mixed traffic, ready flags and sparse FLR
      repeat (200)
      begin
         @(negedge clk_main_a0);
         drive_stat(1'b0);
         drive_rsp();
         ddr_ready_ctl = $random(seed);
         ddr_c_ready   = $random(seed);
         flr_assert    = (($random(seed) & 15) == 0);
      end

      repeat (40)
      begin
         @(negedge clk_main_a0);
         drive_stat(1'b1);
         drive_rsp();
      end

      // FLR, single pulse then held request
      @(negedge clk_main_a0);
      drive_quiet();
      flr_assert = 1'b0;
      repeat (3) @(negedge clk_main_a0);
      flr_assert = 1'b1;
      @(negedge clk_main_a0);
      flr_assert = 1'b0;
      wait_flr_done();
      repeat (3) @(negedge clk_main_a0);
      flr_assert = 1'b1;
      wait_flr_done();
      repeat (6) @(negedge clk_main_a0);        // Done toggles meanwhile
      flr_assert = 1'b0;

      // Let the pipelines drain and the last acks return
      repeat (STAT_STAGES + 2)
      begin
         @(negedge clk_main_a0);
         drive_rsp();
      end

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule : tb_cl_glue

`default_nettype wire

// ==== flist.f ====
verilog/platform_pkg.sv
verilog/stat_bus_pkg.sv
verilog/pipe_stage.sv
verilog/reset_fanout.sv
verilog/shell_ctrl.sv
verilog/stat_bridge.sv
verilog/cl_glue_top.sv
verif/tb_cl_glue.sv

// ==== Bender.yml ====
package:
  name: cl_glue

sources:
  # Packages first, modules import them
  - verilog/platform_pkg.sv
  - verilog/stat_bus_pkg.sv

  # RTL, leaf modules before the top level
  - verilog/pipe_stage.sv
  - verilog/reset_fanout.sv
  - verilog/shell_ctrl.sv
  - verilog/stat_bridge.sv
  - verilog/cl_glue_top.sv

  # Testbench
  - target: test
    files:
      - verif/tb_cl_glue.sv
